//--- Bender.yml
package:
  name: pmp_unit

sources:
  # Packages first, the modules import them
  - rtl/pmp_cfg_pkg.sv
  - rtl/pmp_access_pkg.sv
  - rtl/pmp_csr_regs.sv
  - rtl/pmp_region_match.sv
  - rtl/pmp_perm_resolve.sv
  - rtl/pmp_unit.sv
  - target: test
    files:
      - dv/pmp_unit_checker.sv
      - dv/pmp_unit_tb.sv

//--- dv/pmp_unit_checker.sv
// PMP checker: register and access-rule reference model, response scoreboard
`default_nettype none

module pmp_unit_checker import pmp_cfg_pkg::*; import pmp_access_pkg::*; #(
  parameter int unsigned PMP_NUM_REGIONS = 8
) (
  input  wire logic                  clk,
  input  wire logic                  arst_n_i,
  input  wire logic                  csr_we_i,
  input  wire pmp_csr_sel_e          csr_sel_i,
  input  wire logic [3:0]            csr_idx_i,
  input  wire logic [PMP_ADDR_W-1:0] csr_wdata_i,
  input  wire logic                  req_valid_i,
  input  wire pmp_req_t              req_i,
  input  wire logic                  resp_valid_i,
  input  wire logic                  resp_err_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // One outstanding request and the cycle its response is due
  typedef struct packed {
    logic [PMP_ADDR_W-1:0] addr;
    pmp_acc_e              acc;
    priv_lvl_e             priv;
    logic                  err;
    logic [31:0]           due;
  } expect_t;

  // Model state, cfg byte layout is L at 5, A at 4:3, X W R at 2:0
  logic [5:0]            m_cfg  [PMP_MAX_REGIONS];
  logic [PMP_ADDR_W-1:0] m_addr [PMP_MAX_REGIONS];
  logic                  m_rlb;
  logic                  m_mmwp;
  logic                  m_mml;

  expect_t     exp_q[$];
  expect_t     ent;
  logic [31:0] cyc = '0;
  int unsigned err_mismatch   = 0;
  int unsigned err_missing    = 0;
  int unsigned err_unexpected = 0;
  int unsigned pending_cnt    = 0;

  // --------------------------------------------------
  // Reference rules
  // --------------------------------------------------

  // Byte range [lo, hi) of entry r, compared on full byte addresses
  function automatic logic in_region(int unsigned r, logic [PMP_ADDR_W-1:0] a);
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] size;
    int unsigned k;
    case (m_cfg[r][4:3])
      2'b01: begin
        // TOR spans from the entry below up to this address
        lo = 64'd0;
        if (r != 0) lo = 64'(m_addr[r-1]);
        hi = 64'(m_addr[r]);
      end
      2'b10: begin
        lo = 64'(m_addr[r]);
        hi = lo + 64'd4;
      end
      2'b11: begin
        // Trailing ones of the word address give the size, 8 bytes minimum
        k = 0;
        while (k < 32 && m_addr[r][k+2]) k++;
        size = 64'd8 << k;
        lo   = 64'(m_addr[r]) & ~(size - 64'd1);
        hi   = lo + size;
      end
      default: return 1'b0;
    endcase
    return (64'(a) >= lo) && (64'(a) < hi);
  endfunction

  function automatic logic expect_fault(logic [PMP_ADDR_W-1:0] a, pmp_acc_e acc, priv_lvl_e priv);
    logic m, l, r, w, x, rd, wr, ex, basic, ok;
    int   hit;
    hit = -1;
    // First matching entry wins
    for (int i = 0; i < PMP_NUM_REGIONS && hit < 0; i++) begin
      if (in_region(i, a)) hit = i;
    end
    m  = (priv == PRIV_LVL_M);
    rd = (acc == PMP_ACC_READ);
    wr = (acc == PMP_ACC_WRITE);
    ex = (acc == PMP_ACC_EXEC);
    if (hit < 0) return m_mmwp || !m;
    l = m_cfg[hit][5];
    x = m_cfg[hit][2];
    w = m_cfg[hit][1];
    r = m_cfg[hit][0];
    basic = (rd && r) || (wr && w) || (ex && x);
    if (!m_mml) return m ? (l && !basic) : !basic;
    // Under MML a W without R marks a shared region
    if (w && !r) begin
      if (!l) ok = x ? (rd || wr) : (rd || (wr && m));
      else    ok = x ? (ex || (rd && m)) : ex;
    end else if (l && r && w && x) begin
      ok = rd;
    end else begin
      // Locked rules for M only, unlocked for S and U only
      ok = basic && (l == m);
    end
    return !ok;
  endfunction

  task automatic apply_write(pmp_csr_sel_e sel, logic [3:0] idx, logic [PMP_ADDR_W-1:0] d);
    logic frozen;
    logic base_of_tor;
    logic any_lock;
    frozen      = m_cfg[idx][5] && !m_rlb;
    base_of_tor = 1'b0;
    if (idx < 15) base_of_tor = m_cfg[idx+1][5] && (m_cfg[idx+1][4:3] == 2'b01) && !m_rlb;
    any_lock = 1'b0;
    for (int i = 0; i < PMP_MAX_REGIONS; i++) any_lock |= m_cfg[i][5];
    case (sel)
      CSR_SEL_CFG:  if (idx < PMP_NUM_REGIONS && !frozen) m_cfg[idx] = d[5:0];
      CSR_SEL_ADDR: begin
        if (idx < PMP_NUM_REGIONS && !frozen && !base_of_tor) m_addr[idx] = {d[33:2], 2'b00};
      end
      CSR_SEL_MSECCFG: begin
        // mml and mmwp stick once set
        m_mml  |= d[0];
        m_mmwp |= d[1];
        if (m_rlb || !any_lock) m_rlb = d[2];
      end
      default: ;
    endcase
  endtask

  // --------------------------------------------------
  // Scoreboard
  // --------------------------------------------------

  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < PMP_MAX_REGIONS; i++) begin
        m_cfg[i]  = '0;
        m_addr[i] = '0;
      end
      m_rlb  = 1'b0;
      m_mmwp = 1'b0;
      m_mml  = 1'b0;
      exp_q.delete();
      pending_cnt = 0;
    end else begin
      cyc++;
      while (exp_q.size() != 0 && exp_q[0].due < cyc) begin
        ent = exp_q.pop_front();
        err_missing++;
        $display("%0d ns: no response for request to %h due at cycle %0d", $time, ent.addr,
                 ent.due);
      end
      if (resp_valid_i) begin
        if (exp_q.size() == 0 || exp_q[0].due != cyc) begin
          err_unexpected++;
          $display("%0d ns: response seen with no request due in this cycle", $time);
        end else begin
          ent = exp_q.pop_front();
          if (resp_err_i !== ent.err) begin
            err_mismatch++;
            $display("[FAIL] %0d ns: addr %h %s %s expected err %0b got %b", $time, ent.addr,
                     ent.acc.name(), ent.priv.name(), ent.err, resp_err_i);
          end
        end
      end
      // Expectation uses the state before this edge's CSR write
      if (req_valid_i) begin
        ent.addr = req_i.addr;
        ent.acc  = req_i.acc;
        ent.priv = req_i.priv;
        ent.err  = expect_fault(req_i.addr, req_i.acc, req_i.priv);
        // Two register stages, seen at the second edge after the request
        ent.due  = cyc + 2;
        exp_q.push_back(ent);
      end
      if (csr_we_i) apply_write(csr_sel_i, csr_idx_i, csr_wdata_i);
      pending_cnt = exp_q.size();
    end
  end

endmodule

`default_nettype wire

//--- dv/pmp_unit_tb.sv
// PMP testbench top: clock, reset, seeded random CSR writes and requests, watchdog, summary
`default_nettype none

module pmp_unit_tb
  import pmp_cfg_pkg::*;
  import pmp_access_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned PMP_GRANULARITY = 0;
  localparam int unsigned PMP_NUM_REGIONS = 8;
  localparam int unsigned CLK_PERIOD      = 40;
  localparam int unsigned N_PHASES        = 60;
  localparam int unsigned MAX_CSR         = 6;
  localparam int unsigned MAX_REQ         = 16;
  // Phase length plus slack for drain and the resets between groups
  localparam int unsigned CYC_PER_PHASE   = MAX_CSR + MAX_REQ + 8;
  localparam longint      WATCHDOG_NS     = longint'(N_PHASES * CYC_PER_PHASE + 50) * CLK_PERIOD;
  // Window where regions get programmed
  localparam logic [PMP_ADDR_W-1:0] WIN_BASE = 34'h2_0000_0000;

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic                  csr_we;
  pmp_csr_sel_e          csr_sel;
  logic [3:0]            csr_idx;
  logic [PMP_ADDR_W-1:0] csr_wdata;
  logic                  req_valid;
  pmp_req_t              req;
  logic                  resp_valid;
  logic                  resp_err;

  // Last programmed bounds per index, used to aim requests at edges
  logic [PMP_ADDR_W-1:0] pt_lo  [PMP_MAX_REGIONS];
  logic [PMP_ADDR_W-1:0] pt_hi  [PMP_MAX_REGIONS];
  logic [PMP_ADDR_W-1:0] pt_raw [PMP_MAX_REGIONS];

  always #(CLK_PERIOD / 2) clk = ~clk;

  pmp_unit #(
    .PMP_GRANULARITY (PMP_GRANULARITY),
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) u_pmp_unit (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .csr_we_i     (csr_we),
    .csr_sel_i    (csr_sel),
    .csr_idx_i    (csr_idx),
    .csr_wdata_i  (csr_wdata),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .resp_valid_o (resp_valid),
    .resp_err_o   (resp_err)
  );

  pmp_unit_checker #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) u_chk (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .csr_we_i     (csr_we),
    .csr_sel_i    (csr_sel),
    .csr_idx_i    (csr_idx),
    .csr_wdata_i  (csr_wdata),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .resp_valid_i (resp_valid),
    .resp_err_i   (resp_err)
  );

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic drive_csr_write();
    int unsigned idx;
    int unsigned pick;
    int unsigned k;
    logic [PMP_ADDR_W-1:0] base;
    // Indices 8 and 9 are unimplemented and must be ignored
    idx  = $urandom % 10;
    pick = $urandom % 10;
    csr_we  = 1'b1;
    csr_idx = idx[3:0];
    if (pick < 4) begin
      // Lock kept rare so RLB stays reachable
      csr_sel   = CSR_SEL_CFG;
      csr_wdata = {28'd0, ($urandom % 8 == 0), 2'($urandom), 3'($urandom)};
    end else if (pick < 8) begin
      k = $urandom % 7;
      if ($urandom % 10 == 0) base = WIN_BASE + 34'(($urandom % 16) * 'h200);
      else base = WIN_BASE + 34'(idx * 'h400 + ($urandom % 2) * 'h200);
      csr_sel   = CSR_SEL_ADDR;
      // Trailing ones encode a NAPOT size of 8 << k bytes
      csr_wdata = base | 34'(((1 << k) - 1) << 2);
      pt_lo[idx]  = base;
      pt_hi[idx]  = base + 34'(8 << k);
      pt_raw[idx] = csr_wdata;
    end else begin
      csr_sel   = CSR_SEL_MSECCFG;
      csr_wdata = {31'd0, 1'($urandom % 2), ($urandom % 12 == 0), ($urandom % 12 == 0)};
    end
  endtask

  task automatic drive_request();
    int unsigned pick;
    int unsigned idx;
    int          off;
    logic [PMP_ADDR_W-1:0] a;
    pick = $urandom % 10;
    idx  = $urandom % PMP_NUM_REGIONS;
    // One word below, at, or one word above a bound
    off  = (int'($urandom % 3) - 1) * 4;
    case (pick)
      0, 1:    a = pt_lo[idx] + 34'(off);
      2, 3:    a = pt_hi[idx] + 34'(off);
      4, 5:    a = pt_raw[idx] + 34'(off);
      6, 7:    a = WIN_BASE + 34'($urandom % 'h4000);
      8:       a = {2'($urandom), 32'($urandom)};
      default: a = 34'($urandom % 'h100);
    endcase
    a[1:0]    = 2'($urandom);
    req_valid = 1'b1;
    req.addr  = a;
    req.acc   = pmp_acc_e'(2'($urandom % 3));
    case ($urandom % 3)
      0:       req.priv = PRIV_LVL_U;
      1:       req.priv = PRIV_LVL_S;
      default: req.priv = PRIV_LVL_M;
    endcase
  endtask

  // Idle until every queued request has been answered
  task automatic drain();
    req_valid = 1'b0;
    csr_we    = 1'b0;
    while (u_chk.pending_cnt != 0) next_cycle();
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (3) next_cycle();
    arst_n = 1'b1;
  endtask

  task automatic print_counts();
    $display("Errors: %0d mismatches, %0d missing responses, %0d unexpected responses",
             u_chk.err_mismatch, u_chk.err_missing, u_chk.err_unexpected);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin : main
    int unsigned n;
    void'($urandom(32'h4dd0));
    arst_n    = 1'b0;
    csr_we    = 1'b0;
    csr_sel   = CSR_SEL_CFG;
    csr_idx   = '0;
    csr_wdata = '0;
    req_valid = 1'b0;
    req       = '0;
    for (int i = 0; i < PMP_MAX_REGIONS; i++) begin
      pt_lo[i]  = WIN_BASE;
      pt_hi[i]  = WIN_BASE;
      pt_raw[i] = WIN_BASE;
    end
    repeat (3) next_cycle();
    arst_n = 1'b1;
    for (int ph = 0; ph < N_PHASES; ph++) begin
      // Fresh reset now and then clears the sticky mseccfg bits
      if (ph != 0 && ph % 10 == 0) begin
        drain();
        apply_reset();
      end
      n = 1 + $urandom % MAX_CSR;
      repeat (n) begin
        drive_csr_write();
        next_cycle();
      end
      csr_we = 1'b0;
      // Back-to-back requests, some with a CSR write in the same cycle
      n = 4 + $urandom % (MAX_REQ - 3);
      repeat (n) begin
        csr_we    = 1'b0;
        req_valid = 1'b0;
        if ($urandom % 6 != 0) drive_request();
        if ($urandom % 8 == 0) drive_csr_write();
        next_cycle();
      end
      req_valid = 1'b0;
      csr_we    = 1'b0;
      next_cycle();
    end
    drain();
    repeat (2) next_cycle();
    print_counts();
    if (u_chk.err_mismatch + u_chk.err_missing + u_chk.err_unexpected == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the phase count
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Run did not finish within %0d ns, stimulus or drain is stuck", WATCHDOG_NS);
    print_counts();
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- pmp_unit.f
rtl/pmp_cfg_pkg.sv
rtl/pmp_access_pkg.sv
rtl/pmp_csr_regs.sv
rtl/pmp_region_match.sv
rtl/pmp_perm_resolve.sv
rtl/pmp_unit.sv
dv/pmp_unit_checker.sv
dv/pmp_unit_tb.sv

//--- rtl/pmp_access_pkg.sv
// Access-side types: privilege levels, access types, request and stage 1 to stage 2 payload
`default_nettype none

package pmp_access_pkg;

  // Privilege level, RISC-V encoding (2'b10 is reserved)
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Kind of access being checked
  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_READ  = 2'b10
  } pmp_acc_e;

  // Incoming request, 38 bits
  typedef struct packed {
    logic [pmp_cfg_pkg::PMP_ADDR_W-1:0] addr;
    pmp_acc_e                           acc;
    priv_lvl_e                          priv;
  } pmp_req_t;

  // Result of region matching, carried into the permission stage
  // mml and mmwp are snapshots taken with the request
  typedef struct packed {
    logic                   valid;
    logic                   hit;
    pmp_cfg_pkg::pmp_ncfg_t ncfg;
    pmp_acc_e               acc;
    priv_lvl_e              priv;
    logic                   mml;
    logic                   mmwp;
  } pmp_hit_t;

endpackage

`default_nettype wire

//--- rtl/pmp_cfg_pkg.sv
// PMP configuration types for address modes, entry config, mseccfg, CSR bundle and write selects
`default_nettype none

package pmp_cfg_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------

  // All vectors are sized to the architectural entry count
  localparam int unsigned PMP_MAX_REGIONS = 16;
  // Width of a physical byte address in bits
  localparam int unsigned PMP_ADDR_W      = 34;

  // --------------------------------------------------
  // Entry configuration
  // --------------------------------------------------

  // Address matching mode in the encoding of the pmpcfg A field
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // One entry of 6 bits with read in bit 0
  typedef struct packed {
    logic      lock;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_ncfg_t;

  // Machine security config with mml in bit 0 as in the CSR
  typedef struct packed {
    logic rlb;
    logic mmwp;
    logic mml;
  } mseccfg_t;

  // Complete register state handed to the checker pipeline
  // Addresses are byte addresses with bits 1:0 held at zero
  typedef struct packed {
    pmp_ncfg_t [PMP_MAX_REGIONS-1:0]                 cfg;
    logic      [PMP_MAX_REGIONS-1:0][PMP_ADDR_W-1:0] addr;
    mseccfg_t                                        mseccfg;
  } pmp_csr_t;

  // Which register a CSR write strobe targets
  typedef enum logic [1:0] {
    CSR_SEL_CFG     = 2'b00,
    CSR_SEL_ADDR    = 2'b01,
    CSR_SEL_MSECCFG = 2'b10
  } pmp_csr_sel_e;

endpackage

`default_nettype wire

//--- rtl/pmp_csr_regs.sv
// PMP entry and mseccfg register file with lock, TOR neighbour, RLB and sticky-bit write rules
`default_nettype none

module pmp_csr_regs import pmp_cfg_pkg::*; #(
  parameter int unsigned PMP_NUM_REGIONS = 8
) (
  input  wire logic                  clk,
  input  wire logic                  arst_n_i,
  input  wire logic                  csr_we_i,
  input  wire pmp_csr_sel_e          csr_sel_i,
  input  wire logic [3:0]            csr_idx_i,
  input  wire logic [PMP_ADDR_W-1:0] csr_wdata_i,
  output pmp_csr_t                   csr_pmp_o
);

  // Register state, entries at or above PMP_NUM_REGIONS stay at reset value
  pmp_ncfg_t [PMP_MAX_REGIONS-1:0]                 cfg_q;
  logic      [PMP_MAX_REGIONS-1:0][PMP_ADDR_W-1:0] addr_q;
  mseccfg_t                                        mseccfg_q;

  // Write qualification
  logic [PMP_MAX_REGIONS-1:0] entry_sel;
  logic [PMP_MAX_REGIONS-1:0] entry_locked;
  logic [PMP_MAX_REGIONS-1:0] tor_locked_above;
  logic                       any_locked;
  pmp_ncfg_t                  cfg_wdata;
  mseccfg_t                   sec_wdata;
  mseccfg_t                   sec_nxt;

  // --------------------------------------------------
  // Write rules
  // --------------------------------------------------

  // Low bits of the write data carry the cfg byte or the mseccfg bits
  assign cfg_wdata = pmp_ncfg_t'(csr_wdata_i[5:0]);
  assign sec_wdata = mseccfg_t'(csr_wdata_i[2:0]);

  always_comb begin
    any_locked       = 1'b0;
    tor_locked_above = '0;
    for (int r = 0; r < PMP_MAX_REGIONS; r++) begin
      // Only implemented entries can be addressed
      entry_sel[r]    = (csr_idx_i == 4'(r)) && (r < PMP_NUM_REGIONS);
      // Lock holds unless rule locking bypass is active
      entry_locked[r] = cfg_q[r].lock && !mseccfg_q.rlb;
      any_locked      = any_locked | cfg_q[r].lock;
    end
    // A locked TOR entry also freezes the address below it, which is its base
    for (int r = 0; r < PMP_MAX_REGIONS - 1; r++) begin
      tor_locked_above[r] = cfg_q[r+1].lock && (cfg_q[r+1].mode == PMP_MODE_TOR) &&
                            !mseccfg_q.rlb;
    end
  end

  always_comb begin
    // mml and mmwp only ever get set
    sec_nxt.mml  = mseccfg_q.mml  | sec_wdata.mml;
    sec_nxt.mmwp = mseccfg_q.mmwp | sec_wdata.mmwp;
    // RLB is writable while nothing is locked or while it is already on
    sec_nxt.rlb  = (mseccfg_q.rlb || !any_locked) ? sec_wdata.rlb : mseccfg_q.rlb;
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q     <= '0;
      addr_q    <= '0;
      mseccfg_q <= '0;
    end else if (csr_we_i) begin
      unique case (csr_sel_i)
        CSR_SEL_CFG: begin
          for (int r = 0; r < PMP_MAX_REGIONS; r++) begin
            if (entry_sel[r] && !entry_locked[r]) begin
              cfg_q[r] <= cfg_wdata;
            end
          end
        end
        CSR_SEL_ADDR: begin
          for (int r = 0; r < PMP_MAX_REGIONS; r++) begin
            if (entry_sel[r] && !entry_locked[r] && !tor_locked_above[r]) begin
              // Word aligned, bits 1:0 are not stored
              addr_q[r] <= {csr_wdata_i[PMP_ADDR_W-1:2], 2'b00};
            end
          end
        end
        CSR_SEL_MSECCFG: mseccfg_q <= sec_nxt;
        default: ;
      endcase
    end
  end

  assign csr_pmp_o.cfg     = cfg_q;
  assign csr_pmp_o.addr    = addr_q;
  assign csr_pmp_o.mseccfg = mseccfg_q;

  // Unimplemented entries never leave OFF, whatever was written
  for (genvar r = PMP_NUM_REGIONS; r < PMP_MAX_REGIONS; r++) begin : g_unimpl_chk
    a_unimpl_off: assert property (@(posedge clk) disable iff (!arst_n_i)
      csr_pmp_o.cfg[r].mode == PMP_MODE_OFF);
  end

endmodule

`default_nettype wire

//--- rtl/pmp_perm_resolve.sv
// Stage 2: classic and MML permission rules on the selected entry, registered fault result
`default_nettype none

module pmp_perm_resolve import pmp_access_pkg::*; (
  input  wire logic     clk,
  input  wire logic     arst_n_i,
  input  wire pmp_hit_t hit_i,
  output logic          resp_valid_o,
  output logic          resp_err_o
);

  logic is_m;
  logic is_rd;
  logic is_wr;
  logic is_ex;
  logic basic_perm;
  logic mml_perm;
  logic fault;
  logic resp_valid_q;
  logic resp_err_q;

  // --------------------------------------------------
  // Permission checks
  // --------------------------------------------------

  assign is_m  = (hit_i.priv == PRIV_LVL_M);
  assign is_rd = (hit_i.acc == PMP_ACC_READ);
  assign is_wr = (hit_i.acc == PMP_ACC_WRITE);
  assign is_ex = (hit_i.acc == PMP_ACC_EXEC);

  // Plain R/W/X lookup
  assign basic_perm = (is_rd && hit_i.ncfg.read)  ||
                      (is_wr && hit_i.ncfg.write) ||
                      (is_ex && hit_i.ncfg.exec);

  // Smepmp table, keyed on L R W X
  always_comb begin
    case ({hit_i.ncfg.lock, hit_i.ncfg.read, hit_i.ncfg.write, hit_i.ncfg.exec})
      // Shared data, RW in M, read only in S/U
      4'b0010: mml_perm = is_rd || (is_wr && is_m);
      // Shared data, RW everywhere
      4'b0011: mml_perm = is_rd || is_wr;
      // Shared code, execute only everywhere
      4'b1010: mml_perm = is_ex;
      // Shared code, RX in M and X only in S/U
      4'b1011: mml_perm = is_ex || (is_rd && is_m);
      // Shared read only for all modes
      4'b1111: mml_perm = is_rd;
      // Locked rules belong to M, unlocked rules to S/U
      default: mml_perm = basic_perm && (hit_i.ncfg.lock == is_m);
    endcase
  end

  // --------------------------------------------------
  // Fault decision
  // --------------------------------------------------

  always_comb begin
    if (hit_i.hit) begin
      if (hit_i.mml) begin
        fault = !mml_perm;
      end else if (is_m) begin
        // M-mode is only bound by locked entries
        fault = hit_i.ncfg.lock && !basic_perm;
      end else begin
        fault = !basic_perm;
      end
    end else begin
      // No match, default deny for S/U and for M with mmwp
      fault = hit_i.mmwp || !is_m;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= hit_i.valid;
    end
  end

  // Result only captured for a live request
  always_ff @(posedge clk) begin
    if (hit_i.valid) begin
      resp_err_q <= fault;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_err_o   = resp_err_q;

  // A response cannot be followed by another one without fresh input
  a_no_stuck_resp: assert property (@(posedge clk) disable iff (!arst_n_i)
    resp_valid_o && !hit_i.valid |=> !resp_valid_o);

endmodule

`default_nettype wire

//--- rtl/pmp_region_match.sv
// Stage 1: match request address against all regions and register the lowest-numbered hit
`default_nettype none

module pmp_region_match import pmp_cfg_pkg::*; import pmp_access_pkg::*; #(
  parameter int unsigned PMP_GRANULARITY = 0,
  parameter int unsigned PMP_NUM_REGIONS = 8
) (
  input  wire logic     clk,
  input  wire logic     arst_n_i,
  input  wire logic     req_valid_i,
  input  wire pmp_req_t req_i,
  input  wire pmp_csr_t csr_pmp_i,
  output pmp_hit_t      hit_o
);

  // Lowest address bit that takes part in comparisons
  localparam int unsigned GRAN_LSB = PMP_GRANULARITY + 2;
  // Lowest stored bit that can extend a NAPOT region
  localparam int unsigned ONES_LSB = (PMP_GRANULARITY == 0) ? 2 : PMP_GRANULARITY + 1;

  logic [PMP_NUM_REGIONS-1:0][PMP_ADDR_W-1:0]        region_start;
  logic [PMP_NUM_REGIONS-1:0][PMP_ADDR_W-1:GRAN_LSB] region_mask;
  logic [PMP_NUM_REGIONS-1:0]                        match_eq;
  logic [PMP_NUM_REGIONS-1:0]                        match_ge;
  logic [PMP_NUM_REGIONS-1:0]                        match_lt;
  logic [PMP_NUM_REGIONS-1:0]                        region_match;
  logic                                              match_any;
  pmp_ncfg_t                                         match_cfg;
  pmp_hit_t                                          hit_q;

  // --------------------------------------------------
  // Per-region comparators
  // --------------------------------------------------

  for (genvar r = 0; r < PMP_NUM_REGIONS; r++) begin : g_region

    // TOR base is the previous entry's address, entry 0 starts at zero
    if (r == 0) begin : g_base0
      assign region_start[r] = (csr_pmp_i.cfg[r].mode == PMP_MODE_TOR) ? '0 :
                               csr_pmp_i.addr[r];
    end else begin : g_base
      assign region_start[r] = (csr_pmp_i.cfg[r].mode == PMP_MODE_TOR) ?
                               csr_pmp_i.addr[r-1] : csr_pmp_i.addr[r];
    end

    // NAPOT mask, a bit drops out when every stored bit below it is one
    for (genvar b = GRAN_LSB; b < PMP_ADDR_W; b++) begin : g_mask
      if (b == 2) begin : g_lsb
        // Smallest NAPOT region is 8 bytes so bit 2 never compares
        assign region_mask[r][b] = (csr_pmp_i.cfg[r].mode != PMP_MODE_NAPOT);
      end else begin : g_upper
        assign region_mask[r][b] = (csr_pmp_i.cfg[r].mode != PMP_MODE_NAPOT) ||
                                   !(&csr_pmp_i.addr[r][b-1:ONES_LSB]);
      end
    end

    // Compare only above the granule
    assign match_eq[r] = (req_i.addr[PMP_ADDR_W-1:GRAN_LSB] & region_mask[r]) ==
                         (region_start[r][PMP_ADDR_W-1:GRAN_LSB] & region_mask[r]);
    assign match_ge[r] = req_i.addr[PMP_ADDR_W-1:GRAN_LSB] >=
                         region_start[r][PMP_ADDR_W-1:GRAN_LSB];
    assign match_lt[r] = req_i.addr[PMP_ADDR_W-1:GRAN_LSB] <
                         csr_pmp_i.addr[r][PMP_ADDR_W-1:GRAN_LSB];

    always_comb begin
      unique case (csr_pmp_i.cfg[r].mode)
        PMP_MODE_TOR:   region_match[r] = match_ge[r] && match_lt[r];
        PMP_MODE_NA4:   region_match[r] = match_eq[r];
        PMP_MODE_NAPOT: region_match[r] = match_eq[r];
        default:        region_match[r] = 1'b0;
      endcase
    end
  end

  // --------------------------------------------------
  // Priority select
  // --------------------------------------------------

  // Walk down so the lowest-numbered match is written last
  always_comb begin
    match_any = 1'b0;
    match_cfg = '0;
    for (int r = PMP_NUM_REGIONS - 1; r >= 0; r--) begin
      if (region_match[r]) begin
        match_any = 1'b1;
        match_cfg = csr_pmp_i.cfg[r];
      end
    end
  end

  // Stage register, payload only moves with a request
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hit_q <= '0;
    end else begin
      hit_q.valid <= req_valid_i;
      if (req_valid_i) begin
        hit_q.hit  <= match_any;
        hit_q.ncfg <= match_cfg;
        hit_q.acc  <= req_i.acc;
        hit_q.priv <= req_i.priv;
        // Security mode bits travel with the request
        hit_q.mml  <= csr_pmp_i.mseccfg.mml;
        hit_q.mmwp <= csr_pmp_i.mseccfg.mmwp;
      end
    end
  end

  assign hit_o = hit_q;

  // Every accepted request reaches stage 2 one cycle later
  a_req_to_hit: assert property (@(posedge clk) disable iff (!arst_n_i)
    req_valid_i |=> hit_o.valid);

endmodule

`default_nettype wire

//--- rtl/pmp_unit.sv
// PMP unit top: register file, region match stage and permission stage
`default_nettype none

module pmp_unit import pmp_cfg_pkg::*; import pmp_access_pkg::*; #(
  parameter int unsigned PMP_GRANULARITY = 0,
  parameter int unsigned PMP_NUM_REGIONS = 8
) (
  input  wire logic                  clk,
  input  wire logic                  arst_n_i,
  // CSR write strobe
  input  wire logic                  csr_we_i,
  input  wire pmp_csr_sel_e          csr_sel_i,
  input  wire logic [3:0]            csr_idx_i,
  input  wire logic [PMP_ADDR_W-1:0] csr_wdata_i,
  // Access check request
  input  wire logic                  req_valid_i,
  input  wire pmp_req_t              req_i,
  // Result, two cycles after the request
  output logic                       resp_valid_o,
  output logic                       resp_err_o
);

  pmp_csr_t csr_pmp;
  pmp_hit_t hit_q;

  pmp_csr_regs #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) u_pmp_csr_regs (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_idx_i   (csr_idx_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_pmp_o   (csr_pmp)
  );

  // Stage 1
  pmp_region_match #(
    .PMP_GRANULARITY (PMP_GRANULARITY),
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) u_pmp_region_match (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .csr_pmp_i   (csr_pmp),
    .hit_o       (hit_q)
  );

  // Stage 2
  pmp_perm_resolve u_pmp_perm_resolve (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .hit_i        (hit_q),
    .resp_valid_o (resp_valid_o),
    .resp_err_o   (resp_err_o)
  );

endmodule

`default_nettype wire
